// File: sim.f
swu_pkg.sv
swu_write_ctrl.sv
swu_window_walk.sv
swu_line_buffer.sv
swu_top.sv
swu_checker.sv
tb_swu.sv

// File: run.sh
#!/bin/sh
# compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --timescale 1ns/100ps --top-module tb_swu \
   -f sim.f -o tb_swu &&
./obj_dir/tb_swu +verilator+error+limit+1000 | tee /dev/stderr |
   grep -F -e "=== PASS ===" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb_swu.sv
`timescale 1ns/100ps

module tb_swu;
   import swu_pkg::*;

   localparam int HOLD_CYCLES    = 3 * BUFFER_DEPTH;
   localparam int MAX_FRAMES     = 2;
   // eight times the nominal length of three frames
   localparam int TIMEOUT_CYCLES = 8 * 3 * (OUT_WORDS + FRAME_WORDS);

   logic              clk = 1'b0;
   logic              resetn;
   logic [WORD_W-1:0] in_data_i;
   logic              in_valid_i;
   logic              in_ready_o;
   logic [WORD_W-1:0] out_data_o;
   logic              out_valid_o;
   logic              out_ready_i;

   logic [WORD_W-1:0] frame_data [MAX_FRAMES][FRAME_WORDS];
   logic [31:0]       rng = 32'd44976;
   int                cycle_count = 0;
   int                test_errors = 0;
   int                checker_base = 0;
   int                tests_passed = 0;
   int                tests_failed = 0;

   swu_top u_dut (
      .clk         (clk),
      .resetn      (resetn),
      .in_data_i   (in_data_i),
      .in_valid_i  (in_valid_i),
      .in_ready_o  (in_ready_o),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

   always #20 clk = ~clk;

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("=== FAIL ===");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // stimulus and reference model
   ////////////////////////////////////////////////////////////

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // output k of a frame with channel group fastest and output row slowest
   function automatic logic [WORD_W-1:0] window_word(input int frame, input int k);
      int rest;
      int ch;
      int kw;
      int kh;
      int ocol;
      int orow;
      ch   = k % EFF_CHANNELS;
      rest = k / EFF_CHANNELS;
      kw   = rest % KERNEL_WIDTH;
      rest = rest / KERNEL_WIDTH;
      kh   = rest % KERNEL_HEIGHT;
      rest = rest / KERNEL_HEIGHT;
      ocol = rest % OFM_WIDTH;
      orow = rest / OFM_WIDTH;
      return frame_data[frame][((orow + kh) * IFM_WIDTH + ocol + kw) * EFF_CHANNELS + ch];
   endfunction

   task automatic apply_reset();
      resetn      = 1'b0;
      in_valid_i  = 1'b0;
      in_data_i   = '0;
      out_ready_i = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      resetn = 1'b1;
   endtask

   // streams n frames through the DUT with out_ready_i low for the first hold cycles
   task automatic run_frames(input int n_frames, input bit rand_valid, input bit rand_ready,
                             input int hold_cycles);
      int in_frame;
      int in_idx;
      int out_frame;
      int out_idx;
      int cyc;
      int held_in;
      int extra_out;
      bit in_taken;
      logic [WORD_W-1:0] expected;
      in_frame  = 0;
      in_idx    = 0;
      out_frame = 0;
      out_idx   = 0;
      cyc       = 0;
      held_in   = 0;
      extra_out = 0;
      in_taken  = 1'b0;
      for (int f = 0; f < n_frames; f++) begin
         for (int i = 0; i < FRAME_WORDS; i++) begin
            rng = xorshift32(rng);
            frame_data[f][i] = rng[WORD_W-1:0];
         end
      end
      while (out_frame < n_frames) begin
         // a valid word is held until it is taken
         if (in_taken || !in_valid_i) begin
            rng = xorshift32(rng);
            in_valid_i = (in_frame < n_frames) && (!rand_valid || rng[1:0] != 2'b00);
            in_data_i  = (in_frame < n_frames) ? frame_data[in_frame][in_idx] : '0;
         end
         rng = xorshift32(rng);
         out_ready_i = (cyc >= hold_cycles) && (!rand_ready || rng[2]);
         // outputs for the coming rising edge are settled by the falling edge
         @(negedge clk);
         // frame fully in with more than two outputs to come, so no frame end yet
         if (in_frame > out_frame && OUT_WORDS - out_idx > 2) begin
            assert (!in_ready_o) else begin
               $display("in_ready_o high at %0t while frame %0d is still being read out",
                        $time, out_frame);
               test_errors++;
            end
         end
         in_taken = in_valid_i && in_ready_o;
         if (in_taken) begin
            held_in = held_in + (out_ready_i ? 0 : 1);
            in_idx++;
            if (in_idx == FRAME_WORDS) begin
               in_idx = 0;
               in_frame++;
            end
         end
         if (out_valid_o && out_ready_i) begin
            expected = window_word(out_frame, out_idx);
            assert (out_data_o == expected) else begin
               $display("FAILED at %0t: out_data_o expected %h, got %h",
                        $time, expected, out_data_o);
               test_errors++;
            end
            out_idx++;
            if (out_idx == OUT_WORDS) begin
               out_idx = 0;
               out_frame++;
            end
         end
         if (hold_cycles > 0 && cyc == hold_cycles - 1) begin
            assert (held_in == BUFFER_DEPTH) else begin
               $display("with out_ready_i low, %0d input words were accepted instead of %0d",
                        held_in, BUFFER_DEPTH);
               test_errors++;
            end
         end
         cyc++;
         @(posedge clk);
         #2;
      end
      // nothing may follow the last window
      in_valid_i  = 1'b0;
      out_ready_i = 1'b1;
      repeat (8) begin
         @(negedge clk);
         extra_out = extra_out + (out_valid_o ? 1 : 0);
      end
      @(posedge clk);
      #2;
      assert (extra_out == 0) else begin
         $display("%0d output words came after the last window of the frame", extra_out);
         test_errors++;
      end
   endtask

   task automatic finish_test(input int num, input string name);
      test_errors = test_errors + u_dut.u_checker.fail_count - checker_base;
      $display("test %0d %s: %s, %0d errors", num, name,
               (test_errors == 0) ? "ok" : "failed", test_errors);
      if (test_errors == 0) begin
         tests_passed++;
      end else begin
         tests_failed++;
      end
      test_errors  = 0;
      checker_base = u_dut.u_checker.fail_count;
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      apply_reset();
      repeat (2) @(posedge clk);
      #2;
      finish_test(1, "reset state");
      run_frames(1, 1'b0, 1'b0, 0);
      finish_test(2, "full rate frame");
      run_frames(1, 1'b0, 1'b1, 0);
      finish_test(3, "random output back-pressure");
      apply_reset();
      run_frames(1, 1'b0, 1'b0, HOLD_CYCLES);
      finish_test(4, "output stalled from reset");
      run_frames(2, 1'b1, 1'b1, 0);
      finish_test(5, "back-to-back random frames");
      $display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
      if (tests_failed == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

// File: swu_checker.sv
`timescale 1ns/100ps

module swu_checker (
   input logic                       clk,
   input logic                       resetn,
   input logic                       in_ready_i,
   input logic [swu_pkg::WORD_W-1:0] out_data_i,
   input logic                       out_valid_i,
   input logic                       out_ready_i,
   input logic                       rd_ready_i
);
   // assertion failures counted so far
   int fail_count = 0;

   ////////////////////////////////////////////////////////////
   // stream protocol
   ////////////////////////////////////////////////////////////

   // any reset cycle leaves the streams idle and open for input
   reset_state: assert property (@(posedge clk) !resetn |=> (!out_valid_i && in_ready_i))
      else begin
         fail_count++;
         $error("output valid or input ready wrong after reset");
      end

   // a stalled output word stays in place
   output_hold: assert property (@(posedge clk) disable iff (!resetn)
      (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_data_i)))
      else begin
         fail_count++;
         $error("output word dropped or changed under back-pressure");
      end

   // no read can issue, so the window cannot retire and free space
   input_stall: assert property (@(posedge clk) disable iff (!resetn)
      (!in_ready_i && !rd_ready_i && !out_ready_i) |=> !in_ready_i)
      else begin
         fail_count++;
         $error("input ready rose while the read pipeline was stalled");
      end

endmodule

bind swu_top swu_checker u_checker (
   .clk         (clk),
   .resetn      (resetn),
   .in_ready_i  (in_ready_o),
   .out_data_i  (out_data_o),
   .out_valid_i (out_valid_o),
   .out_ready_i (out_ready_i),
   .rd_ready_i  (rd_ready)
);

// File: swu_top.sv
`timescale 1ns/100ps

module swu_top (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic [swu_pkg::WORD_W-1:0] in_data_i,
   input  logic                       in_valid_i,
   output logic                       in_ready_o,
   output logic [swu_pkg::WORD_W-1:0] out_data_o,
   output logic                       out_valid_o,
   input  logic                       out_ready_i
);
   import swu_pkg::*;

   logic              wr_en;
   logic [ADDR_W-1:0] wr_addr;
   logic [IDX_W-1:0]  written_count;
   logic [IDX_W-1:0]  oldest_idx;
   logic              frame_done;
   logic              rd_en;
   logic [IDX_W-1:0]  rd_idx;
   logic              rd_ready;

   ////////////////////////////////////////////////////////////
   // input side
   ////////////////////////////////////////////////////////////

   swu_write_ctrl u_write_ctrl (
      .clk             (clk),
      .resetn          (resetn),
      .in_valid_i      (in_valid_i),
      .in_ready_o      (in_ready_o),
      .oldest_idx_i    (oldest_idx),
      .frame_done_i    (frame_done),
      .written_count_o (written_count),
      .wr_en_o         (wr_en),
      .wr_addr_o       (wr_addr)
   );

   ////////////////////////////////////////////////////////////
   // window sequencing and storage
   ////////////////////////////////////////////////////////////

   swu_window_walk u_window_walk (
      .clk             (clk),
      .resetn          (resetn),
      .written_count_i (written_count),
      .rd_ready_i      (rd_ready),
      .rd_en_o         (rd_en),
      .rd_idx_o        (rd_idx),
      .oldest_idx_o    (oldest_idx),
      .frame_done_o    (frame_done)
   );

   // write data goes straight from the input stream
   swu_line_buffer u_line_buffer (
      .clk         (clk),
      .resetn      (resetn),
      .wr_en_i     (wr_en),
      .wr_addr_i   (wr_addr),
      .wr_data_i   (in_data_i),
      .rd_en_i     (rd_en),
      .rd_idx_i    (rd_idx),
      .rd_ready_o  (rd_ready),
      .out_data_o  (out_data_o),
      .out_valid_o (out_valid_o),
      .out_ready_i (out_ready_i)
   );

endmodule

// File: swu_line_buffer.sv
`timescale 1ns/100ps

module swu_line_buffer (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic                       wr_en_i,
   input  logic [swu_pkg::ADDR_W-1:0] wr_addr_i,
   input  logic [swu_pkg::WORD_W-1:0] wr_data_i,
   input  logic                       rd_en_i,
   input  logic [swu_pkg::IDX_W-1:0]  rd_idx_i,
   output logic                       rd_ready_o,
   output logic [swu_pkg::WORD_W-1:0] out_data_o,
   output logic                       out_valid_o,
   input  logic                       out_ready_i
);
   import swu_pkg::*;

   logic [WORD_W-1:0] mem [BUFFER_DEPTH];

   logic [ADDR_W-1:0] rd_addr;
   logic [WORD_W-1:0] s1_data_q;
   logic              s1_valid_q;
   logic [WORD_W-1:0] s2_data_q;
   logic              s2_valid_q;
   logic              s2_take;

   ////////////////////////////////////////////////////////////
   // circular storage
   ////////////////////////////////////////////////////////////

   // frame index wraps modulo the depth
   assign rd_addr = rd_idx_i[ADDR_W-1:0];

   always_ff @(posedge clk) begin
      if (wr_en_i) begin
         mem[wr_addr_i] <= wr_data_i;
      end
   end

   ////////////////////////////////////////////////////////////
   // two stage read pipeline
   ////////////////////////////////////////////////////////////

   // output stage is free or hands its word over this cycle
   assign s2_take = out_ready_i | ~s2_valid_q;

   // first stage is free or moves on into the output stage
   assign rd_ready_o = ~s1_valid_q | s2_take;

   // stage 1 is the synchronous memory read
   always_ff @(posedge clk) begin
      if (!resetn) begin
         s1_valid_q <= 1'b0;
      end else if (rd_ready_o) begin
         s1_valid_q <= rd_en_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en_i && rd_ready_o) begin
         s1_data_q <= mem[rd_addr];
      end
   end

   // stage 2 drives the output stream and holds under back-pressure
   always_ff @(posedge clk) begin
      if (!resetn) begin
         s2_valid_q <= 1'b0;
      end else if (s2_take) begin
         s2_valid_q <= s1_valid_q;
      end
   end

   always_ff @(posedge clk) begin
      if (s1_valid_q && s2_take) begin
         s2_data_q <= s1_data_q;
      end
   end

   assign out_data_o  = s2_data_q;
   assign out_valid_o = s2_valid_q;

endmodule

// File: swu_window_walk.sv
`timescale 1ns/100ps

module swu_window_walk (
   input  logic                      clk,
   input  logic                      resetn,
   input  logic [swu_pkg::IDX_W-1:0] written_count_i,
   input  logic                      rd_ready_i,
   output logic                      rd_en_o,
   output logic [swu_pkg::IDX_W-1:0] rd_idx_o,
   output logic [swu_pkg::IDX_W-1:0] oldest_idx_o,
   output logic                      frame_done_o
);
   import swu_pkg::*;

   logic [CH_W-1:0]  ch_q;
   logic [KW_W-1:0]  kw_q;
   logic [KH_W-1:0]  kh_q;
   logic [OW_W-1:0]  ocol_q;
   logic [OH_W-1:0]  orow_q;

   logic             last_ch;
   logic             last_kw;
   logic             last_kh;
   logic             last_ocol;
   logic             last_orow;

   logic [IDX_W-1:0] in_row;
   logic [IDX_W-1:0] in_col;
   logic [IDX_W-1:0] need_idx;

   ////////////////////////////////////////////////////////////
   // index of the word the walk needs next
   ////////////////////////////////////////////////////////////

   assign in_row = IDX_W'(orow_q) + IDX_W'(kh_q);
   assign in_col = IDX_W'(ocol_q) + IDX_W'(kw_q);

   // pixel index times channel groups, plus the group
   assign need_idx = IDX_W'((in_row * IFM_WIDTH + in_col) * EFF_CHANNELS + ch_q);

   // top left word of the current window
   assign oldest_idx_o = IDX_W'((orow_q * IFM_WIDTH + ocol_q) * EFF_CHANNELS);

   // only read what has already been written this frame
   assign rd_en_o  = rd_ready_i & (need_idx < written_count_i);
   assign rd_idx_o = need_idx;

   ////////////////////////////////////////////////////////////
   // counter wrap points
   ////////////////////////////////////////////////////////////

   assign last_ch   = ch_q == CH_W'(EFF_CHANNELS - 1);
   assign last_kw   = kw_q == KW_W'(KERNEL_WIDTH - 1);
   assign last_kh   = kh_q == KH_W'(KERNEL_HEIGHT - 1);
   assign last_ocol = ocol_q == OW_W'(OFM_WIDTH - 1);
   assign last_orow = orow_q == OH_W'(OFM_HEIGHT - 1);

   assign frame_done_o = rd_en_o & last_ch & last_kw & last_kh & last_ocol & last_orow;

   ////////////////////////////////////////////////////////////
   // nested walk counters
   ////////////////////////////////////////////////////////////

   // channel group runs fastest, output row slowest
   always_ff @(posedge clk) begin
      if (!resetn) begin
         ch_q   <= '0;
         kw_q   <= '0;
         kh_q   <= '0;
         ocol_q <= '0;
         orow_q <= '0;
      end else if (rd_en_o) begin
         ch_q <= last_ch ? '0 : ch_q + 1'b1;
         if (last_ch) begin
            kw_q <= last_kw ? '0 : kw_q + 1'b1;
            if (last_kw) begin
               kh_q <= last_kh ? '0 : kh_q + 1'b1;
               if (last_kh) begin
                  // window complete, step to the next output position
                  ocol_q <= last_ocol ? '0 : ocol_q + 1'b1;
                  if (last_ocol) begin
                     // wraps to zero together with frame_done
                     orow_q <= last_orow ? '0 : orow_q + 1'b1;
                  end
               end
            end
         end
      end
   end

endmodule

// File: swu_write_ctrl.sv
`timescale 1ns/100ps

module swu_write_ctrl (
   input  logic                       clk,
   input  logic                       resetn,
   input  logic                       in_valid_i,
   output logic                       in_ready_o,
   input  logic [swu_pkg::IDX_W-1:0]  oldest_idx_i,
   input  logic                       frame_done_i,
   output logic [swu_pkg::IDX_W-1:0]  written_count_o,
   output logic                       wr_en_o,
   output logic [swu_pkg::ADDR_W-1:0] wr_addr_o
);
   import swu_pkg::*;

   logic [IDX_W-1:0] written_count_q;
   logic [IDX_W-1:0] fill;
   logic             frame_open;
   logic             room_left;

   ////////////////////////////////////////////////////////////
   // acceptance rules
   ////////////////////////////////////////////////////////////

   // words held in the buffer that the current window may still read
   assign fill = written_count_q - oldest_idx_i;

   // stop once the whole frame is in
   assign frame_open = written_count_q < IDX_W'(FRAME_WORDS);

   // never get a full buffer depth ahead of the oldest needed word
   assign room_left = fill < IDX_W'(BUFFER_DEPTH);

   assign in_ready_o = frame_open & room_left;

   ////////////////////////////////////////////////////////////
   // write port
   ////////////////////////////////////////////////////////////

   assign wr_en_o = in_valid_i & in_ready_o;

   // circular placement, depth is a power of two
   assign wr_addr_o = written_count_q[ADDR_W-1:0];

   ////////////////////////////////////////////////////////////
   // frame write counter
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!resetn) begin
         written_count_q <= '0;
      end else if (frame_done_i) begin
         // last window issued, next frame starts at index 0
         written_count_q <= '0;
      end else if (wr_en_o) begin
         written_count_q <= written_count_q + 1'b1;
      end
   end

   assign written_count_o = written_count_q;

endmodule

// File: swu_pkg.sv
package swu_pkg;

   ////////////////////////////////////////////////////////////
   // stream word format
   ////////////////////////////////////////////////////////////

   localparam int SIMD         = 4;
   localparam int IP_PRECISION = 2;
   localparam int WORD_W       = SIMD * IP_PRECISION;

   ////////////////////////////////////////////////////////////
   // image and kernel geometry
   ////////////////////////////////////////////////////////////

   localparam int IFM_CHANNELS  = 8;
   // channel groups folded into one pixel
   localparam int EFF_CHANNELS  = IFM_CHANNELS / SIMD;
   localparam int IFM_WIDTH     = 5;
   localparam int IFM_HEIGHT    = 5;
   localparam int KERNEL_WIDTH  = 3;
   localparam int KERNEL_HEIGHT = 3;
   localparam int OFM_WIDTH     = IFM_WIDTH - KERNEL_WIDTH + 1;
   localparam int OFM_HEIGHT    = IFM_HEIGHT - KERNEL_HEIGHT + 1;

   ////////////////////////////////////////////////////////////
   // buffer sizing and word counts
   ////////////////////////////////////////////////////////////

   localparam int FRAME_WORDS  = IFM_WIDTH * IFM_HEIGHT * EFF_CHANNELS;
   // power of two, covers the 26 words one window spans
   localparam int BUFFER_DEPTH = 32;
   localparam int ADDR_W       = $clog2(BUFFER_DEPTH);
   // index has to hold FRAME_WORDS itself for the write counter
   localparam int IDX_W        = $clog2(FRAME_WORDS + 1);
   localparam int WINDOW_WORDS = KERNEL_WIDTH * KERNEL_HEIGHT * EFF_CHANNELS;
   localparam int OUT_WORDS    = OFM_WIDTH * OFM_HEIGHT * WINDOW_WORDS;

   // walk counter widths, at least one bit each
   localparam int CH_W = (EFF_CHANNELS > 1) ? $clog2(EFF_CHANNELS) : 1;
   localparam int KW_W = (KERNEL_WIDTH > 1) ? $clog2(KERNEL_WIDTH) : 1;
   localparam int KH_W = (KERNEL_HEIGHT > 1) ? $clog2(KERNEL_HEIGHT) : 1;
   localparam int OW_W = (OFM_WIDTH > 1) ? $clog2(OFM_WIDTH) : 1;
   localparam int OH_W = (OFM_HEIGHT > 1) ? $clog2(OFM_HEIGHT) : 1;

endpackage
